//--- project.f
+incdir+design
design/llm_pkg.sv
design/llm_if.sv
design/llm_free_list.sv
design/llm_link_table.sv
design/llm_chain_builder.sv
design/llm_chain_reader.sv
design/llm_top.sv
bench/llm_clock_gen.sv
bench/llm_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the llm page manager testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -Wno-fatal --top-module llm_tb -f project.f --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vllm_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0

//--- bench/llm_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm testbench
// directed packet tests against a page order model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "llm_defs.svh"

module llm_tb;

  localparam int PAGE_BUDGET     = 500;   // 1 + 35 + 64 + 320 pages, rounded up
  localparam int CYCLES_PER_PAGE = 40;
  localparam int TIMEOUT_CYCLES  = PAGE_BUDGET * CYCLES_PER_PAGE;
  localparam int MAX_STALL       = 5;

  logic            clk;
  logic            reset;
  logic            pkt_srdy;
  logic            pkt_drdy;
  llm_pkg::len_t   pkt_len;
  logic            out_srdy;
  logic            out_drdy;
  llm_pkg::page_t  out_page;
  logic            out_last;
  llm_pkg::count_t free_count;

  int pkt_lens[$];    // packets of the current test
  int next_k   = 0;   // pages allocated so far in the model
  int cycles   = 0;

  llm_clock_gen clock_gen_i (.clk (clk), .reset (reset));

  llm_top llm_top_i
    (.clk        (clk),
     .reset      (reset),
     .pkt_srdy   (pkt_srdy),
     .pkt_drdy   (pkt_drdy),
     .pkt_len    (pkt_len),
     .out_srdy   (out_srdy),
     .out_drdy   (out_drdy),
     .out_page   (out_page),
     .out_last   (out_last),
     .free_count (free_count));

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the DUT stopped moving pages", cycles);
      stop_run();
    end
  end

  task automatic stop_run();
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    stop_run();
  endtask

  task automatic compare_page(input string what, input llm_pkg::page_t got,
                              input llm_pkg::page_t exp);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic compare_count(input string what, input llm_pkg::count_t got,
                               input llm_pkg::count_t exp);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  task automatic compare_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
      report_mismatch(what, 32'(got), 32'(exp));
  endtask

  // k-th page allocated overall, since pages come back in allocation order
  function automatic llm_pkg::page_t predicted_page(input int k);
    return llm_pkg::page_t'(k % `LLM_PAGES);
  endfunction

  task automatic send_packets();
    bit taken;
    foreach (pkt_lens[p])
    begin
      pkt_srdy = 1'b1;
      pkt_len  = llm_pkg::len_t'(pkt_lens[p]);
      taken    = 1'b0;
      while (!taken)
      begin
        @(negedge clk);
        taken = pkt_drdy;   // transfer on the coming edge
        @(posedge clk);
        #1;
      end
      pkt_srdy = 1'b0;
    end
  endtask

  task automatic receive_pages(input bit stall);
    int             j;
    int             stall_left;
    bit             shown;
    bit             taken;
    llm_pkg::page_t exp_page;
    logic           exp_last;
    foreach (pkt_lens[p])
    begin
      for (j = 0; j < pkt_lens[p]; j++)
      begin
        exp_page   = predicted_page(next_k);
        exp_last   = (j == pkt_lens[p] - 1);
        stall_left = stall ? $urandom_range(MAX_STALL, 0) : 0;
        shown      = 1'b0;
        taken      = 1'b0;
        while (!taken)
        begin
          out_drdy = (stall_left == 0);
          @(negedge clk);
          if (out_srdy)
          begin
            // checked every cycle it is offered, so a stalled page must hold
            compare_page("out_page", out_page, exp_page);
            compare_flag("out_last", out_last, exp_last);
            shown = 1'b1;
            taken = out_drdy;
            if (stall_left > 0)
              stall_left--;
          end
          else if (shown)
          begin
            $display("out_srdy dropped at %0t before page %0d was taken", $time, next_k);
            stop_run();
          end
          @(posedge clk);
          #1;
        end
        next_k++;
      end
    end
    out_drdy = 1'b0;
  endtask

  task automatic transfer_packets(input bit stall);
    fork
      send_packets();
      receive_pages(stall);
    join
  endtask

  task automatic check_idle(input string when);
    @(negedge clk);
    compare_count({"free_count after ", when}, free_count, `LLM_PAGES);
    compare_flag({"out_srdy after ", when}, out_srdy, 1'b0);
    compare_flag({"pkt_drdy after ", when}, pkt_drdy, 1'b1);
    @(posedge clk);
    #1;
  endtask

  task automatic single_page_packet();
    pkt_lens = {1};
    transfer_packets(1'b0);   // page 0 with out_last
    check_idle("one page packet");
  endtask

  task automatic length_sweep();
    int len;
    pkt_lens.delete();
    for (len = 2; len <= `LLM_MAX_LEN; len++)
      pkt_lens.push_back(len);
    transfer_packets(1'b0);
    check_idle("length sweep");
  endtask

  task automatic stalled_output();
    int n;
    pkt_lens.delete();
    for (n = 0; n < 8; n++)
      pkt_lens.push_back($urandom_range(`LLM_MAX_LEN, 1));
    transfer_packets(1'b1);
    check_idle("stalled output");
  endtask

  task automatic random_traffic();
    int n;
    pkt_lens.delete();
    for (n = 0; n < 40; n++)
      pkt_lens.push_back($urandom_range(`LLM_MAX_LEN, 1));
    transfer_packets(1'b0);   // wraps the page numbers several times
    check_idle("random traffic");
  endtask

  initial
  begin
    pkt_srdy = 1'b0;
    pkt_len  = '0;
    out_drdy = 1'b0;
    void'($urandom(32'hda6f_82e2));
    @(negedge reset);
    @(posedge clk);
    #1;
    check_idle("reset");
    single_page_packet();
    length_sweep();
    stalled_output();
    random_traffic();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- bench/llm_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module llm_clock_gen
  (
   output logic clk,
   output logic reset
   );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // period 8
  end

  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

//--- design/llm_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm top
// page manager: free list, links, builder, reader
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module llm_top
  (
   input                   clk,
   input                   reset,

   // packet in
   input                   pkt_srdy,
   output logic            pkt_drdy,
   input  llm_pkg::len_t   pkt_len,

   // pages out
   output logic            out_srdy,
   input                   out_drdy,
   output llm_pkg::page_t  out_page,
   output logic            out_last,

   output llm_pkg::count_t free_count
   );

  llm_page_req_if page_req ();
  llm_link_if     link_bus ();

  logic           head_srdy;
  logic           head_drdy;
  llm_pkg::page_t head_page;
  llm_pkg::page_t rd_page;
  llm_pkg::link_t rd_link;
  logic           free_stb;
  llm_pkg::page_t free_page;

  llm_free_list free_list_i
    (.clk        (clk),
     .reset      (reset),
     .req        (page_req.allocator),
     .free_stb   (free_stb),
     .free_page  (free_page),
     .free_count (free_count));

  llm_link_table link_table_i
    (.clk     (clk),
     .link    (link_bus.tbl),
     .rd_page (rd_page),
     .rd_link (rd_link));

  llm_chain_builder chain_builder_i
    (.clk       (clk),
     .reset     (reset),
     .pkt_srdy  (pkt_srdy),
     .pkt_drdy  (pkt_drdy),
     .pkt_len   (pkt_len),
     .req       (page_req.requester),
     .link      (link_bus.writer),
     .head_srdy (head_srdy),
     .head_drdy (head_drdy),
     .head_page (head_page));

  llm_chain_reader chain_reader_i
    (.clk       (clk),
     .reset     (reset),
     .head_srdy (head_srdy),
     .head_drdy (head_drdy),
     .head_page (head_page),
     .rd_page   (rd_page),
     .rd_link   (rd_link),
     .out_srdy  (out_srdy),
     .out_drdy  (out_drdy),
     .out_page  (out_page),
     .out_last  (out_last),
     .free_stb  (free_stb),
     .free_page (free_page));

endmodule

//--- design/llm_chain_reader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm chain reader
// walks a chain, outputs and frees its pages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "llm_defs.svh"

module llm_chain_reader
  (
   input                  clk,
   input                  reset,

   input                  head_srdy,
   output logic           head_drdy,
   input  llm_pkg::page_t head_page,

   // link table lookup
   output llm_pkg::page_t rd_page,
   input  llm_pkg::link_t rd_link,

   output logic           out_srdy,
   input                  out_drdy,
   output llm_pkg::page_t out_page,
   output logic           out_last,

   output logic           free_stb,
   output llm_pkg::page_t free_page
   );

  llm_pkg::read_state_t state;
  llm_pkg::page_t       cur;
  logic                 stop;
  logic                 out_xfer;

  assign stop     = rd_link[`LLM_PAGE_BITS];
  assign out_xfer = out_srdy && out_drdy;

  assign head_drdy = (state == llm_pkg::read_idle);
  assign rd_page   = cur;   // held through present, so rd_link stays put

  assign out_srdy = (state == llm_pkg::read_present);
  assign out_page = cur;
  assign out_last = stop;

  // page goes back as it leaves
  assign free_stb  = out_xfer;
  assign free_page = cur;

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= llm_pkg::read_idle;
    else
    begin
      case (state)
        llm_pkg::read_idle:
          if (head_srdy)
          begin
            cur   <= head_page;
            state <= llm_pkg::read_fetch;
          end
        llm_pkg::read_fetch:
          state <= llm_pkg::read_present;   // link valid next cycle
        llm_pkg::read_present:
          if (out_xfer)
          begin
            if (stop)
              state <= llm_pkg::read_idle;
            else
            begin
              cur   <= rd_link[`LLM_PAGE_BITS-1:0];
              state <= llm_pkg::read_fetch;
            end
          end
        default:
          state <= llm_pkg::read_idle;
      endcase
    end
  end

endmodule

//--- design/llm_chain_builder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm chain builder
// allocates and links the pages of a packet
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module llm_chain_builder
  (
   input                   clk,
   input                   reset,

   input                   pkt_srdy,
   output logic            pkt_drdy,
   input  llm_pkg::len_t   pkt_len,

   llm_page_req_if.requester req,
   llm_link_if.writer      link,

   output logic            head_srdy,
   input                   head_drdy,
   output llm_pkg::page_t  head_page
   );

  llm_pkg::build_state_t state;
  llm_pkg::len_t         len_left;   // pages still to allocate
  llm_pkg::page_t        cur;        // newest page
  llm_pkg::page_t        prev;       // page before it
  llm_pkg::page_t        head;
  logic                  first;
  logic                  fwd_pend;   // prev -> cur not yet written

  assign pkt_drdy      = (state == llm_pkg::build_idle);
  assign req.par_srdy  = (state == llm_pkg::build_request);
  assign req.parr_drdy = (state == llm_pkg::build_wait_reply);
  assign link.lnp_srdy = (state == llm_pkg::build_link);
  assign head_srdy     = (state == llm_pkg::build_send);
  assign head_page     = head;

  // forward link first, then the self link with stop set
  assign link.lnp_page = fwd_pend ? prev : cur;
  assign link.lnp_next = fwd_pend ? {1'b0, cur} : {1'b1, cur};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= llm_pkg::build_idle;
      first    <= 1'b0;
      fwd_pend <= 1'b0;
    end
    else
    begin
      case (state)
        llm_pkg::build_idle:
          if (pkt_srdy)
          begin
            len_left <= pkt_len;
            first    <= 1'b1;
            state    <= llm_pkg::build_request;
          end
        llm_pkg::build_request:
          if (req.par_drdy)
            state <= llm_pkg::build_wait_reply;
        llm_pkg::build_wait_reply:
          if (req.parr_srdy)
          begin
            cur      <= req.parr_page;
            prev     <= cur;
            len_left <= len_left - 1'b1;
            first    <= 1'b0;
            if (first)
            begin
              head <= req.parr_page;
              // lone first page still needs its stop link
              state <= (len_left == 1) ? llm_pkg::build_link : llm_pkg::build_request;
            end
            else
            begin
              fwd_pend <= 1'b1;
              state    <= llm_pkg::build_link;
            end
          end
        llm_pkg::build_link:
          if (link.lnp_drdy)
          begin
            fwd_pend <= 1'b0;
            if (fwd_pend && len_left != 0)
              state <= llm_pkg::build_request;
            else if (!fwd_pend)
              state <= llm_pkg::build_send;   // stop link done
          end
        llm_pkg::build_send:
          if (head_drdy)
            state <= llm_pkg::build_idle;   // chain handed to reader
        default:
          state <= llm_pkg::build_idle;
      endcase
    end
  end

endmodule

//--- design/llm_link_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm link table
// next-page memory, one write port, registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "llm_defs.svh"

module llm_link_table
  (
   input                  clk,
   llm_link_if.tbl        link,
   input  llm_pkg::page_t rd_page,
   output llm_pkg::link_t rd_link
   );

  llm_pkg::link_t link_mem [`LLM_PAGES];
  llm_pkg::page_t rd_addr;

  // writes never stall
  assign link.lnp_drdy = 1'b1;

  always_ff @(posedge clk)
  begin
    if (link.lnp_srdy && link.lnp_drdy)
      link_mem[link.lnp_page] <= link.lnp_next;
  end

  // address captured here, data out the next cycle
  always_ff @(posedge clk)
  begin
    rd_addr <= rd_page;
  end

  // a write and a read of one entry in the same cycle
  // shows the new link
  assign rd_link = link_mem[rd_addr];

endmodule

//--- design/llm_free_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm free list
// fresh pages first, then recycled pages in FIFO order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "llm_defs.svh"

module llm_free_list
  (
   input                   clk,
   input                   reset,
   llm_page_req_if.allocator req,
   input                   free_stb,
   input  llm_pkg::page_t  free_page,
   output llm_pkg::count_t free_count
   );

  llm_pkg::page_t  fifo_mem [`LLM_PAGES];
  llm_pkg::page_t  wr_ptr;
  llm_pkg::page_t  rd_ptr;
  llm_pkg::count_t fifo_cnt;
  llm_pkg::count_t fresh_used;   // pages handed out from the counter
  logic            pending;      // request taken, reply owed
  logic            fresh_left;
  logic            avail;
  logic            reply_xfer;
  logic            pop_fifo;

  assign fresh_left = (fresh_used != llm_pkg::count_t'(`LLM_PAGES));
  assign avail      = fresh_left || (fifo_cnt != '0);
  assign reply_xfer = req.parr_srdy && req.parr_drdy;
  assign pop_fifo   = reply_xfer && !fresh_left;

  // one request in flight at a time
  assign req.par_drdy  = !pending;
  assign req.parr_srdy = pending && avail;   // held low while empty
  assign req.parr_page = fresh_left ? fresh_used[`LLM_PAGE_BITS-1:0] : fifo_mem[rd_ptr];

  assign free_count = llm_pkg::count_t'(`LLM_PAGES) - fresh_used + fifo_cnt;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pending    <= 1'b0;
      fresh_used <= '0;
      fifo_cnt   <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
    end
    else
    begin
      if (req.par_srdy && req.par_drdy)
        pending <= 1'b1;
      else if (reply_xfer)
        pending <= 1'b0;

      if (reply_xfer && fresh_left)
        fresh_used <= fresh_used + 1'b1;

      if (pop_fifo)
        rd_ptr <= rd_ptr + 1'b1;
      if (free_stb)
        wr_ptr <= wr_ptr + 1'b1;   // wraps with the page count

      fifo_cnt <= fifo_cnt + llm_pkg::count_t'(free_stb) - llm_pkg::count_t'(pop_fifo);
    end
  end

  // returned pages, readable the cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (free_stb)
      fifo_mem[wr_ptr] <= free_page;
  end

endmodule

//--- design/llm_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm bus interfaces
// page request/reply and link write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// request a page, then take the reply
interface llm_page_req_if;
  logic           par_srdy;
  logic           par_drdy;
  logic           parr_srdy;
  logic           parr_drdy;
  llm_pkg::page_t parr_page;

  modport requester (output par_srdy, input par_drdy,
                     input parr_srdy, output parr_drdy, input parr_page);

  modport allocator (input par_srdy, output par_drdy,
                     output parr_srdy, input parr_drdy, output parr_page);
endinterface

// write one next-page entry
interface llm_link_if;
  logic           lnp_srdy;
  logic           lnp_drdy;
  llm_pkg::page_t lnp_page;   // entry being written
  llm_pkg::link_t lnp_next;   // stop bit and successor

  modport writer (output lnp_srdy, input lnp_drdy, output lnp_page, output lnp_next);

  modport tbl (input lnp_srdy, output lnp_drdy, input lnp_page, input lnp_next);
endinterface

//--- design/llm_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm types
// page, link, length, count and FSM state types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "llm_defs.svh"

package llm_pkg;

  typedef logic [`LLM_PAGE_BITS-1:0] page_t;

  // stop bit on top, next page below
  typedef logic [`LLM_PAGE_BITS:0] link_t;

  typedef logic [$clog2(`LLM_MAX_LEN+1)-1:0] len_t;    // 1..max legal
  typedef logic [$clog2(`LLM_PAGES+1)-1:0] count_t;    // 0..pages

  typedef enum logic [2:0] {
    build_idle,
    build_request,
    build_wait_reply,
    build_link,
    build_send
  } build_state_t;

  typedef enum logic [1:0] {read_idle, read_fetch, read_present} read_state_t;

endpackage

//--- design/llm_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llm sizing defines
// page address width, page count, packet length limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef LLM_DEFS_SVH
`define LLM_DEFS_SVH

// width of a page number
`define LLM_PAGE_BITS 4

// pages in the buffer, one per page number
`define LLM_PAGES 16

// longest packet, in pages
`define LLM_MAX_LEN 8

`endif
